// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_rv_soc
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
rtl/rv_pkg.sv
rtl/wb_if.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_core.sv
rtl/wb_arbiter.sv
rtl/wb_ram.sv
rtl/rv_soc_top.sv
sim/tb_rv_soc.sv

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu
(
    input  rv_pkg::alu_op_t         i_op,
    input  logic [rv_pkg::XLEN-1:0] i_a,
    input  logic [rv_pkg::XLEN-1:0] i_b,
    input  rv_pkg::br_kind_t        i_br,
    output logic [rv_pkg::XLEN-1:0] o_result,
    output logic                    o_take
);

    logic lt_s;
    logic lt_u;

    // shared compares for slt and branches
    assign lt_s = $signed(i_a) < $signed(i_b);
    assign lt_u = i_a < i_b;

    always_comb
    begin
        case (i_op)
            rv_pkg::ALU_ADD:    o_result = i_a + i_b;
            rv_pkg::ALU_SUB:    o_result = i_a - i_b;
            rv_pkg::ALU_SLT:    o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
            rv_pkg::ALU_SLTU:   o_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
            rv_pkg::ALU_AND:    o_result = i_a & i_b;
            rv_pkg::ALU_OR:     o_result = i_a | i_b;
            rv_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            rv_pkg::ALU_PASS_B: o_result = i_b;
            default:            o_result = '0;
        endcase
    end

    // branch condition, jumps always taken
    always_comb
    begin
        case (i_br)
            rv_pkg::BR_EQ:   o_take = i_a == i_b;
            rv_pkg::BR_NE:   o_take = i_a != i_b;
            rv_pkg::BR_LT:   o_take = lt_s;
            rv_pkg::BR_GE:   o_take = !lt_s;
            rv_pkg::BR_JUMP: o_take = 1'b1;
            default:         o_take = 1'b0;
        endcase
    end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_start,
    wb_if.master                    fetch,
    wb_if.master                    data,
    output logic                    o_halted,
    output rv_pkg::trap_t           o_trap_cause,
    output logic [rv_pkg::XLEN-1:0] o_pc
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_HALT
    } state_t;

    state_t                  state;
    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] instr;
    logic [rv_pkg::XLEN-1:0] regs [32];
    rv_pkg::ctrl_t           ctrl;
    logic [4:0]              rs1_addr;
    logic [4:0]              rs2_addr;
    logic [4:0]              rd_addr;
    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] br_target;
    logic [rv_pkg::XLEN-1:0] wb_data;
    logic                    take;
    logic                    rd_we;
    logic                    misaligned;

    rv_decode u_rv_decode
    (
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    rv_alu u_rv_alu
    (
        .i_op     (ctrl.alu_op),
        .i_a      (op_a),
        .i_b      (op_b),
        .i_br     (ctrl.br),
        .o_result (alu_res),
        .o_take   (take)
    );

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    // x0 always reads zero
    assign rs1_val = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    assign op_a     = ctrl.a_pc ? pc : rs1_val;
    assign op_b     = ctrl.b_imm ? ctrl.imm : rs2_val;
    assign pc_plus4 = pc + 32'd4;

    // jalr target drops bit 0
    assign br_target = ctrl.jalr ? {alu_res[rv_pkg::XLEN-1:1], 1'b0} : pc + ctrl.imm;

    // word accesses only, low address bits must be zero
    assign misaligned = (ctrl.load || ctrl.store) && (alu_res[1:0] != 2'b00);
    assign rd_we      = ctrl.reg_we && (rd_addr != 5'd0);

    always_comb
    begin
        case (ctrl.wb_sel)
            rv_pkg::WB_ALU:  wb_data = alu_res;
            rv_pkg::WB_RET:  wb_data = pc_plus4;
            rv_pkg::WB_LOAD: wb_data = data.dat_r;
            default:         wb_data = '0;
        endcase
    end

    // fetch master, read only
    assign fetch.cyc   = (state == ST_FETCH);
    assign fetch.stb   = (state == ST_FETCH);
    assign fetch.we    = 1'b0;
    assign fetch.adr   = pc;
    assign fetch.dat_w = '0;

    // data master, instr and regs stay put through MEM
    assign data.cyc   = (state == ST_MEM);
    assign data.stb   = (state == ST_MEM);
    assign data.we    = ctrl.store;
    assign data.adr   = alu_res;
    assign data.dat_w = rs2_val;

    // instruction latch
    always_ff @(posedge clk)
    begin
        if (state == ST_FETCH && fetch.ack)
            instr <= fetch.dat_r;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= ST_IDLE;
            pc           <= '0;
            o_trap_cause <= rv_pkg::TRAP_NONE;
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (i_start)
                    begin
                        pc    <= '0;
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH:
                begin
                    if (fetch.ack)
                        state <= ST_EXEC;
                end
                ST_EXEC:
                begin
                    // traps leave pc on the faulting instruction
                    if (ctrl.trap != rv_pkg::TRAP_NONE)
                    begin
                        o_trap_cause <= ctrl.trap;
                        state        <= ST_HALT;
                    end
                    else if (misaligned)
                    begin
                        o_trap_cause <= rv_pkg::TRAP_MISALIGN;
                        state        <= ST_HALT;
                    end
                    else if (ctrl.load || ctrl.store)
                        state <= ST_MEM;
                    else
                    begin
                        if (rd_we)
                            regs[rd_addr] <= wb_data;
                        pc    <= take ? br_target : pc_plus4;
                        state <= ST_FETCH;
                    end
                end
                ST_MEM:
                begin
                    // load data lands with ack
                    if (data.ack)
                    begin
                        if (rd_we)
                            regs[rd_addr] <= wb_data;
                        pc    <= pc_plus4;
                        state <= ST_FETCH;
                    end
                end
                ST_HALT:
                    state <= ST_HALT;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    assign o_halted = (state == ST_HALT);
    assign o_pc     = pc;

    // fetch address held until the ram acks
    a_fetch_steady: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch.cyc && !fetch.ack) |=> $stable(fetch.adr));

    // data request held steady until ack
    a_data_steady: assert property (@(posedge clk) disable iff (!rst_n)
        (data.cyc && !data.ack) |=> $stable(data.adr) && $stable(data.we)
            && $stable(data.dat_w));

endmodule

// ==== rtl/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
(
    input  logic [rv_pkg::XLEN-1:0] i_instr,
    output rv_pkg::ctrl_t           o_ctrl
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // instruction table
    always_comb
    begin
        o_ctrl        = '0;
        o_ctrl.alu_op = rv_pkg::ALU_ADD;
        o_ctrl.br     = rv_pkg::BR_NONE;
        o_ctrl.wb_sel = rv_pkg::WB_NONE;
        o_ctrl.trap   = rv_pkg::TRAP_NONE;
        case (opcode)
            rv_pkg::OP_LUI:
            begin
                o_ctrl.alu_op = rv_pkg::ALU_PASS_B;
                o_ctrl.b_imm  = 1'b1;
                o_ctrl.imm    = imm_u;
                o_ctrl.wb_sel = rv_pkg::WB_ALU;
                o_ctrl.reg_we = 1'b1;
            end
            rv_pkg::OP_AUIPC:
            begin
                o_ctrl.a_pc   = 1'b1;
                o_ctrl.b_imm  = 1'b1;
                o_ctrl.imm    = imm_u;
                o_ctrl.wb_sel = rv_pkg::WB_ALU;
                o_ctrl.reg_we = 1'b1;
            end
            rv_pkg::OP_JAL:
            begin
                // target is pc + imm, link is pc + 4
                o_ctrl.br     = rv_pkg::BR_JUMP;
                o_ctrl.imm    = imm_j;
                o_ctrl.wb_sel = rv_pkg::WB_RET;
                o_ctrl.reg_we = 1'b1;
            end
            rv_pkg::OP_JALR:
            begin
                // target comes from the alu, rs1 + imm
                o_ctrl.b_imm  = 1'b1;
                o_ctrl.imm    = imm_i;
                o_ctrl.br     = rv_pkg::BR_JUMP;
                o_ctrl.jalr   = 1'b1;
                o_ctrl.wb_sel = rv_pkg::WB_RET;
                o_ctrl.reg_we = 1'b1;
                if (funct3 != 3'b000)
                    o_ctrl.trap = rv_pkg::TRAP_ILLEGAL;
            end
            rv_pkg::OP_BRANCH:
            begin
                // rs1 vs rs2, compare done in the alu
                o_ctrl.alu_op = rv_pkg::ALU_SUB;
                o_ctrl.imm    = imm_b;
                case (funct3)
                    3'b000:  o_ctrl.br = rv_pkg::BR_EQ;
                    3'b001:  o_ctrl.br = rv_pkg::BR_NE;
                    3'b100:  o_ctrl.br = rv_pkg::BR_LT;
                    3'b101:  o_ctrl.br = rv_pkg::BR_GE;
                    default: o_ctrl.trap = rv_pkg::TRAP_ILLEGAL;
                endcase
            end
            rv_pkg::OP_LOAD:
            begin
                // word loads only
                o_ctrl.b_imm  = 1'b1;
                o_ctrl.imm    = imm_i;
                o_ctrl.load   = 1'b1;
                o_ctrl.wb_sel = rv_pkg::WB_LOAD;
                o_ctrl.reg_we = 1'b1;
                if (funct3 != 3'b010)
                    o_ctrl.trap = rv_pkg::TRAP_ILLEGAL;
            end
            rv_pkg::OP_STORE:
            begin
                o_ctrl.b_imm = 1'b1;
                o_ctrl.imm   = imm_s;
                o_ctrl.store = 1'b1;
                if (funct3 != 3'b010)
                    o_ctrl.trap = rv_pkg::TRAP_ILLEGAL;
            end
            rv_pkg::OP_IMM:
            begin
                // addi is the only immediate alu op here
                o_ctrl.b_imm  = 1'b1;
                o_ctrl.imm    = imm_i;
                o_ctrl.wb_sel = rv_pkg::WB_ALU;
                o_ctrl.reg_we = 1'b1;
                if (funct3 != 3'b000)
                    o_ctrl.trap = rv_pkg::TRAP_ILLEGAL;
            end
            rv_pkg::OP_REG:
            begin
                o_ctrl.wb_sel = rv_pkg::WB_ALU;
                o_ctrl.reg_we = 1'b1;
                // funct7 and funct3 together
                case ({funct7, funct3})
                    10'b0000000_000: o_ctrl.alu_op = rv_pkg::ALU_ADD;
                    10'b0100000_000: o_ctrl.alu_op = rv_pkg::ALU_SUB;
                    10'b0000000_010: o_ctrl.alu_op = rv_pkg::ALU_SLT;
                    10'b0000000_011: o_ctrl.alu_op = rv_pkg::ALU_SLTU;
                    10'b0000000_100: o_ctrl.alu_op = rv_pkg::ALU_XOR;
                    10'b0000000_110: o_ctrl.alu_op = rv_pkg::ALU_OR;
                    10'b0000000_111: o_ctrl.alu_op = rv_pkg::ALU_AND;
                    default:         o_ctrl.trap   = rv_pkg::TRAP_ILLEGAL;
                endcase
            end
            rv_pkg::OP_SYSTEM:
            begin
                if (i_instr == rv_pkg::INSTR_ECALL)
                    o_ctrl.trap = rv_pkg::TRAP_ECALL;
                else if (i_instr == rv_pkg::INSTR_EBREAK)
                    o_ctrl.trap = rv_pkg::TRAP_EBREAK;
                else
                    o_ctrl.trap = rv_pkg::TRAP_ILLEGAL;
            end
            default:
                o_ctrl.trap = rv_pkg::TRAP_ILLEGAL;
        endcase
    end

endmodule

// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    // data and address width
    localparam int XLEN = 32;

    // shared ram depth in words
    localparam int RAM_WORDS = 256;
    // word index width, taken from adr[RAM_AW+1:2]
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // rv32i major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // full system encodings
    localparam logic [XLEN-1:0] INSTR_ECALL  = 32'h0000_0073;
    localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JUMP
    } br_kind_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_RET,
        WB_LOAD,
        WB_NONE
    } wb_sel_t;

    typedef enum logic [2:0] {
        TRAP_NONE,
        TRAP_ECALL,
        TRAP_EBREAK,
        TRAP_MISALIGN,
        TRAP_ILLEGAL
    } trap_t;

    // one decoded instruction
    typedef struct packed {
        alu_op_t         alu_op;
        // operand a is pc instead of rs1
        logic            a_pc;
        // operand b is the immediate instead of rs2
        logic            b_imm;
        br_kind_t        br;
        logic            jalr;
        wb_sel_t         wb_sel;
        logic            reg_we;
        logic            load;
        logic            store;
        trap_t           trap;
        logic [XLEN-1:0] imm;
    } ctrl_t;

endpackage

// ==== rtl/rv_soc_top.sv ====
`timescale 1ns/1ps

module rv_soc_top
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_start,
    input  logic                    i_ld_cyc,
    input  logic                    i_ld_stb,
    input  logic                    i_ld_we,
    input  logic [rv_pkg::XLEN-1:0] i_ld_adr,
    input  logic [rv_pkg::XLEN-1:0] i_ld_dat,
    output logic [rv_pkg::XLEN-1:0] o_ld_dat,
    output logic                    o_ld_ack,
    output logic                    o_halted,
    output rv_pkg::trap_t           o_trap_cause,
    output logic [rv_pkg::XLEN-1:0] o_pc
);

    wb_if if_fetch ();
    wb_if if_data ();
    wb_if if_ld ();
    wb_if if_ram ();

    // loader pins onto its bundle
    assign if_ld.cyc   = i_ld_cyc;
    assign if_ld.stb   = i_ld_stb;
    assign if_ld.we    = i_ld_we;
    assign if_ld.adr   = i_ld_adr;
    assign if_ld.dat_w = i_ld_dat;
    assign o_ld_dat    = if_ld.dat_r;
    assign o_ld_ack    = if_ld.ack;

    rv_core u_rv_core
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (i_start),
        .fetch        (if_fetch.master),
        .data         (if_data.master),
        .o_halted     (o_halted),
        .o_trap_cause (o_trap_cause),
        .o_pc         (o_pc)
    );

    // fetch on m0, data on m1, loader on m2
    wb_arbiter u_wb_arbiter
    (
        .clk   (clk),
        .rst_n (rst_n),
        .m0    (if_fetch.slave),
        .m1    (if_data.slave),
        .m2    (if_ld.slave),
        .s     (if_ram.master)
    );

    wb_ram u_wb_ram
    (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (if_ram.slave)
    );

endmodule

// ==== rtl/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter
(
    input logic  clk,
    input logic  rst_n,
    wb_if.slave  m0,
    wb_if.slave  m1,
    wb_if.slave  m2,
    wb_if.master s
);

    logic [2:0] req;
    logic [2:0] grant;
    logic [2:0] nxt_grant;
    logic [1:0] last;
    logic [1:0] nxt_last;
    logic       hold;

    assign req  = {m2.cyc, m1.cyc, m0.cyc};
    // granted master still in its cycle
    assign hold = |(grant & req);

    // round robin, search starts after the last winner
    always_comb
    begin
        nxt_grant = '0;
        nxt_last  = last;
        for (int k = 1; k <= 3; k++)
        begin
            if (nxt_grant == 3'b000 && req[(last + k) % 3])
            begin
                nxt_grant[(last + k) % 3] = 1'b1;
                nxt_last = 2'((last + k) % 3);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            grant <= '0;
            // m0 wins first
            last  <= 2'd2;
        end
        else if (!hold)
        begin
            grant <= nxt_grant;
            if (nxt_grant != 3'b000)
                last <= nxt_last;
        end
    end

    // request path to the slave
    always_comb
    begin
        case (grant)
            3'b001:  {s.cyc, s.stb, s.we, s.adr, s.dat_w} = {m0.cyc, m0.stb, m0.we, m0.adr, m0.dat_w};
            3'b010:  {s.cyc, s.stb, s.we, s.adr, s.dat_w} = {m1.cyc, m1.stb, m1.we, m1.adr, m1.dat_w};
            3'b100:  {s.cyc, s.stb, s.we, s.adr, s.dat_w} = {m2.cyc, m2.stb, m2.we, m2.adr, m2.dat_w};
            default: {s.cyc, s.stb, s.we, s.adr, s.dat_w} = '0;
        endcase
    end

    // responses only to the granted master
    assign m0.ack   = grant[0] && s.ack;
    assign m1.ack   = grant[1] && s.ack;
    assign m2.ack   = grant[2] && s.ack;
    assign m0.dat_r = grant[0] ? s.dat_r : '0;
    assign m1.dat_r = grant[1] ? s.dat_r : '0;
    assign m2.dat_r = grant[2] ? s.dat_r : '0;

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

    // a slave ack always finds exactly one owner
    a_ack_owner: assert property (@(posedge clk) disable iff (!rst_n)
        s.ack |-> $onehot({m2.ack, m1.ack, m0.ack}));

endmodule

// ==== rtl/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;

    // request side, driven by the master
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [rv_pkg::XLEN-1:0] adr;
    logic [rv_pkg::XLEN-1:0] dat_w;

    // response side, driven by the slave
    logic [rv_pkg::XLEN-1:0] dat_r;
    logic                    ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

// ==== rtl/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram
(
    input logic clk,
    input logic rst_n,
    wb_if.slave bus
);

    logic [rv_pkg::XLEN-1:0]   mem [rv_pkg::RAM_WORDS];
    logic [rv_pkg::RAM_AW-1:0] idx;
    logic                      req;

    // word index, byte offset ignored
    assign idx = bus.adr[rv_pkg::RAM_AW+1:2];
    // new request, not yet acknowledged
    assign req = bus.cyc && bus.stb && !bus.ack;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            bus.ack <= 1'b0;
        else
            bus.ack <= req;
    end

    // write and read on the edge that raises ack
    always_ff @(posedge clk)
    begin
        if (req)
        begin
            if (bus.we)
                mem[idx] <= bus.dat_w;
            bus.dat_r <= mem[idx];
        end
    end

endmodule

// ==== sim/rv_testdata.txt ====
// record: word count, program words from address 0, trap cause, final pc,
// probe address (ffffffff none), probe value, check count, address/value pairs
// causes 1 ecall, 2 ebreak, 3 misaligned; a zero word count ends the list

// alu and immediates, loader probes 0x300 during the run
00000016
00500093 FFD00113 002081B3 40208233 001122B3 00113333 0020F3B3 0020E433
0020C4B3 12345537 00001597 20000613 00362023 00462223 00562423 00662623
00762823 00862A23 00962C23 00A62E23 02B62023 00100073
00000002 00000054
00000300 5A5A1234
00000009
00000200 00000002
00000204 00000008
00000208 00000001
0000020C 00000000
00000210 00000005
00000214 FFFFFFFD
00000218 FFFFFFF8
0000021C 12345000
00000220 00001028

// branches taken and not taken, jal and jalr links
00000020
24000613 00100093 00200113 FFF00193 00000293 00108463 00128293 00208463
01028293 00209463 00128293 00109463 02028293 0011C463 00128293 0030C463
04028293 0030D463 00128293 0011D463 08028293 00C0036F 00128293 00128293
07000393 00138467 00128293 00128293 00562023 00662223 00862423 00100073
00000002 0000007C
FFFFFFFF 00000000
00000003
00000240 000000F0
00000244 00000058
00000248 00000068

// store then load, writes to x0 are dropped
0000000A
28000613 CAFE00B7 12308093 00162023 00062103 00062003 00508013 00262223
00062423 00100073
00000002 00000024
FFFFFFFF 00000000
00000003
00000280 CAFE0123
00000284 CAFE0123
00000288 00000000

// misaligned lw halts before the second store
00000006
2C000613 00700093 00162023 00262103 00162223 00100073
00000003 0000000C
FFFFFFFF 00000000
00000002
000002C0 00000007
000002C4 BEEF02C4

// ecall halts before the second store
00000005
2E000613 00900093 00162023 00000073 00162223
00000001 0000000C
FFFFFFFF 00000000
00000002
000002E0 00000009
000002E4 BEEF02E4

00000000

// ==== sim/tb_rv_soc.sv ====
`timescale 1ns/1ps

module tb_rv_soc;

    // testdata image size and wait limits
    localparam int          TD_WORDS   = 512;
    localparam int          ACK_LIMIT  = 100;
    localparam int          HALT_LIMIT = 4000;
    localparam int          MAX_PROGS  = 16;
    // loader readback area, above every program result
    localparam int          LT_WORDS   = 8;
    localparam logic [31:0] LT_BASE    = 32'h0000_0380;
    localparam logic [31:0] NO_PROBE   = 32'hFFFF_FFFF;

    logic          clk;
    logic          rst_n;
    logic          i_start;
    logic          i_ld_cyc;
    logic          i_ld_stb;
    logic          i_ld_we;
    logic [31:0]   i_ld_adr;
    logic [31:0]   i_ld_dat;
    logic [31:0]   o_ld_dat;
    logic          o_ld_ack;
    logic          o_halted;
    rv_pkg::trap_t o_trap_cause;
    logic [31:0]   o_pc;

    logic [31:0] tdata [TD_WORDS];
    int          seed = 31;
    int          n_checks;
    int          n_mismatch;
    int          n_other;

    rv_soc_top u_rv_soc_top
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (i_start),
        .i_ld_cyc     (i_ld_cyc),
        .i_ld_stb     (i_ld_stb),
        .i_ld_we      (i_ld_we),
        .i_ld_adr     (i_ld_adr),
        .i_ld_dat     (i_ld_dat),
        .o_ld_dat     (o_ld_dat),
        .o_ld_ack     (o_ld_ack),
        .o_halted     (o_halted),
        .o_trap_cause (o_trap_cause),
        .o_pc         (o_pc)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_mismatch++;
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // testdata word, zero past the end of the image
    function automatic logic [31:0] data_word(input int p);
        if (p >= 0 && p < TD_WORDS)
            return tdata[p];
        return 32'd0;
    endfunction

    // background pattern, differs for every byte address
    function automatic logic [31:0] fill_value(input logic [31:0] adr);
        return adr ^ 32'hBEEF_0000;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n    <= 1'b0;
        i_start  <= 1'b0;
        i_ld_cyc <= 1'b0;
        i_ld_stb <= 1'b0;
        i_ld_we  <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    // one loader transfer on the shared bus
    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int   n;
        logic acked;
        acked = 1'b0;
        rdat  = '0;
        @(posedge clk);
        i_ld_cyc <= 1'b1;
        i_ld_stb <= 1'b1;
        i_ld_we  <= we;
        i_ld_adr <= adr;
        i_ld_dat <= wdat;
        // ack sampled mid cycle, away from the edge
        for (n = 0; n < ACK_LIMIT && !acked; n++)
        begin
            @(negedge clk);
            if (o_ld_ack)
            begin
                acked = 1'b1;
                rdat  = o_ld_dat;
            end
        end
        @(posedge clk);
        i_ld_cyc <= 1'b0;
        i_ld_stb <= 1'b0;
        i_ld_we  <= 1'b0;
        if (!acked)
        begin
            n_other++;
            $display("loader access to address %h got no ack within %0d cycles",
                     adr, ACK_LIMIT);
        end
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic fill_ram();
        int i;
        for (i = 0; i < rv_pkg::RAM_WORDS; i++)
            write_word(32'(i * 4), fill_value(32'(i * 4)));
    endtask

    // loader alone, random gaps between transfers
    task automatic loader_test();
        logic [31:0] pattern [LT_WORDS];
        logic [31:0] rdat;
        int          gap;
        int          i;
        for (i = 0; i < LT_WORDS; i++)
        begin
            pattern[i] = $random(seed);
            write_word(LT_BASE + 32'(i * 4), pattern[i]);
            gap = $random(seed) & 3;
            repeat (gap) @(posedge clk);
        end
        // read back in reverse order
        for (i = LT_WORDS - 1; i >= 0; i--)
        begin
            bus_access(1'b0, LT_BASE + 32'(i * 4), '0, rdat);
            compare_word(rdat, pattern[i],
                         $sformatf("loader readback at %h", LT_BASE + 32'(i * 4)));
            gap = $random(seed) & 3;
            repeat (gap) @(posedge clk);
        end
    endtask

    // one testdata record: load, run to halt, check state and memory
    task automatic run_program(input int prog, inout int ptr);
        int          n_words;
        int          n_pairs;
        int          n;
        int          i;
        logic [31:0] exp_cause;
        logic [31:0] exp_pc;
        logic [31:0] probe_adr;
        logic [31:0] probe_val;
        logic [31:0] adr;
        logic [31:0] rdat;
        logic        halted;

        n_words = int'(data_word(ptr));
        ptr++;
        apply_reset();
        fill_ram();
        for (i = 0; i < n_words; i++)
            write_word(32'(i * 4), data_word(ptr + i));
        ptr += n_words;
        exp_cause = data_word(ptr);
        exp_pc    = data_word(ptr + 1);
        probe_adr = data_word(ptr + 2);
        probe_val = data_word(ptr + 3);
        n_pairs   = int'(data_word(ptr + 4));
        ptr += 5;
        if (probe_adr != NO_PROBE)
            write_word(probe_adr, probe_val);

        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;

        // loader contends with fetch and data while the core runs
        halted = 1'b0;
        for (n = 0; n < HALT_LIMIT && !halted; n++)
        begin
            if (probe_adr != NO_PROBE)
            begin
                bus_access(1'b0, probe_adr, '0, rdat);
                compare_word(rdat, probe_val,
                             $sformatf("program %0d probe read at %h", prog, probe_adr));
            end
            @(negedge clk);
            halted = o_halted;
        end
        if (!halted)
        begin
            n_other++;
            $display("program %0d: the halt did not arrive within %0d cycles",
                     prog, HALT_LIMIT);
        end

        compare_word(32'(o_trap_cause), exp_cause, $sformatf("program %0d trap cause", prog));
        compare_word(o_pc, exp_pc, $sformatf("program %0d final pc", prog));
        for (i = 0; i < n_pairs; i++)
        begin
            adr = data_word(ptr + 2 * i);
            bus_access(1'b0, adr, '0, rdat);
            compare_word(rdat, data_word(ptr + 2 * i + 1),
                         $sformatf("program %0d word at %h", prog, adr));
        end
        ptr += 2 * n_pairs;
    endtask

    initial
    begin
        int ptr;
        int prog;
        int i;
        clk        = 1'b0;
        rst_n      = 1'b0;
        i_start    = 1'b0;
        i_ld_cyc   = 1'b0;
        i_ld_stb   = 1'b0;
        i_ld_we    = 1'b0;
        i_ld_adr   = '0;
        i_ld_dat   = '0;
        n_checks   = 0;
        n_mismatch = 0;
        n_other    = 0;
        for (i = 0; i < TD_WORDS; i++)
            tdata[i] = '0;
        $readmemh("sim/rv_testdata.txt", tdata);

        apply_reset();
        loader_test();

        // records until a zero word count
        ptr  = 0;
        prog = 0;
        while (data_word(ptr) != 32'd0 && prog < MAX_PROGS)
        begin
            prog++;
            run_program(prog, ptr);
        end
        if (prog == 0)
        begin
            n_other++;
            $display("no program records were found in sim/rv_testdata.txt");
        end

        $display("checks %0d, mismatches %0d, other failures %0d",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
